// ==== design/architecture.sv ====
package architecture;

    localparam int dataWidth  = 16;
    localparam int instrWidth = 32;
    localparam int regCount   = 16;

    // instruction field positions.
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 26;
    localparam int rdMsb     = 25;
    localparam int rdLsb     = 22;
    localparam int rsMsb     = 21;
    localparam int rsLsb     = 18;
    localparam int immMsb    = 15;
    localparam int immLsb    = 0;

    typedef enum logic [5:0] {
        ADC_I,  ADC_R,  UADC_I, UADC_R, ADD_I,  ADD_R,  UADD_I, UADD_R,
        AND_I,  AND_R,  TST_I,  TST_R,  OR_I,   OR_R,   SBB_I,  SBB_R,
        USBB_I, USBB_R, CMP_I,  CMP_R,  SUB_I,  SUB_R,  UCMP_I, UCMP_R,
        USUB_I, USUB_R, RCL_I,  RCL_R,  RCR_I,  RCR_R,  ROL_I,  ROL_R,
        ROR_I,  ROR_R,  SAR_I,  SAR_R,  SHL_I,  SHL_R,  SHR_I,  SHR_R,
        NOT_R,  SMUL_R, UMUL_R, SDIV_R, UDIV_R,
        LOAD,   STORE,  MOV_I,  HALT
    } opcodes;

    typedef enum logic [3:0] {
        FETCH0, FETCH1, FETCH2, FETCH3,
        DECODE,
        EXECUTE0, EXECUTE1,
        MEMORY0, MEMORY1, MEMORY2, MEMORY3,
        HALTED
    } states;

    // Owning unit of an opcode, one-hot as {divider, multiplier, shifter, alu}.
    // Zero means no unit is involved.
    function automatic logic [3:0] unitOf(opcodes op);
        case (op)
            ADC_I, ADC_R, UADC_I, UADC_R, ADD_I, ADD_R, UADD_I, UADD_R,
            AND_I, AND_R, TST_I, TST_R, OR_I, OR_R, NOT_R,
            SBB_I, SBB_R, USBB_I, USBB_R, CMP_I, CMP_R, SUB_I, SUB_R,
            UCMP_I, UCMP_R, USUB_I, USUB_R:                   unitOf = 4'b0001;
            RCL_I, RCL_R, RCR_I, RCR_R, ROL_I, ROL_R, ROR_I, ROR_R,
            SAR_I, SAR_R, SHL_I, SHL_R, SHR_I, SHR_R:         unitOf = 4'b0010;
            SMUL_R, UMUL_R:                                   unitOf = 4'b0100;
            SDIV_R, UDIV_R:                                   unitOf = 4'b1000;
            default:                                          unitOf = 4'b0000;
        endcase
    endfunction

endpackage

// ==== design/execIf.sv ====
`timescale 1ns/1ps

interface execIf import architecture::*; ();

    logic                 start;
    opcodes               op;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic                 carryIn;
    logic [dataWidth-1:0] result;
    logic                 carryOut;
    logic                 done;

    modport issuer (output start, op, opA, opB, carryIn, input result, carryOut, done);
    modport unit (input start, op, opA, opB, carryIn, output result, carryOut, done);

endinterface

// ==== design/stallLogic.sv ====
`timescale 1ns/1ps

module stallLogic import architecture::*; (
    input  states  state,
    input  opcodes instruction,
    input  logic   waitRequest,
    input  logic   readValid,
    input  logic   aluDone,
    input  logic   shifterDone,
    input  logic   multiplierDone,
    input  logic   dividerDone,

    output logic   enable
);

    logic [3:0] owner;
    logic [3:0] doneFlags;

    assign owner     = unitOf(instruction);
    assign doneFlags = {dividerDone, multiplierDone, shifterDone, aluDone};

    always_comb begin
        case (state)
            // no owning unit means nothing to wait for.
            EXECUTE0:        enable = (owner == 4'b0000) || |(owner & doneFlags);

            FETCH1,
            MEMORY1:         enable = !waitRequest;

            FETCH3:          enable = readValid;
            MEMORY3:         enable = readValid || (instruction == STORE); // store has no data.

            default:         enable = 1'b1;
        endcase
    end

endmodule

// ==== design/controller.sv ====
`timescale 1ns/1ps

module controller import architecture::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    input  logic [instrWidth-1:0] readData,

    output states                 state,
    output opcodes                opcode,
    output logic [dataWidth-1:0]  address,
    output logic                  read,
    output logic                  write,
    output logic [instrWidth-1:0] writeData,
    output logic                  halted,

    execIf.issuer                 aluBus,
    execIf.issuer                 shifterBus,
    execIf.issuer                 multiplierBus,
    execIf.issuer                 dividerBus
);

    logic [dataWidth-1:0]   regs [regCount];
    logic [instrWidth-1:0]  instr;
    logic [dataWidth-1:0]   pc;
    logic                   carry;
    logic [rdMsb-rdLsb:0]   rd;
    logic [rsMsb-rsLsb:0]   rs;
    logic [dataWidth-1:0]   imm;
    logic [dataWidth-1:0]   rdValue;
    logic [dataWidth-1:0]   operandB;
    logic [dataWidth-1:0]   memAddress;
    logic [dataWidth-1:0]   unitResult;
    logic                   unitCarry;
    logic [3:0]             owner;
    logic                   immForm;
    logic                   compareOnly;
    logic                   issue;
    states                  nextState;

    assign opcode     = opcodes'(instr[opcodeMsb:opcodeLsb]);
    assign rd         = instr[rdMsb:rdLsb];
    assign rs         = instr[rsMsb:rsLsb];
    assign imm        = instr[immMsb:immLsb];
    assign rdValue    = regs[rd];
    assign memAddress = regs[rs] + imm;
    assign owner      = unitOf(opcode);
    assign halted     = (state == HALTED);
    assign writeData  = {{(instrWidth - dataWidth){1'b0}}, rdValue};

    assign immForm = opcode inside {ADC_I, UADC_I, ADD_I, UADD_I, AND_I, TST_I, OR_I,
                                    SBB_I, USBB_I, CMP_I, SUB_I, UCMP_I, USUB_I, RCL_I,
                                    RCR_I, ROL_I, ROR_I, SAR_I, SHL_I, SHR_I, MOV_I};
    assign compareOnly = opcode inside {TST_I, TST_R, CMP_I, CMP_R, UCMP_I, UCMP_R};
    assign operandB    = immForm ? imm : regs[rs];

    // start is high in DECODE, units latch on the edge into EXECUTE0.
    assign issue = (state == DECODE);

    assign aluBus.start        = issue && owner[0];
    assign aluBus.op           = opcode;
    assign aluBus.opA          = rdValue;
    assign aluBus.opB          = operandB;
    assign aluBus.carryIn      = carry;
    assign shifterBus.start    = issue && owner[1];
    assign shifterBus.op       = opcode;
    assign shifterBus.opA      = rdValue;
    assign shifterBus.opB      = operandB;
    assign shifterBus.carryIn  = carry;
    assign multiplierBus.start   = issue && owner[2];
    assign multiplierBus.op      = opcode;
    assign multiplierBus.opA     = rdValue;
    assign multiplierBus.opB     = operandB;
    assign multiplierBus.carryIn = carry;
    assign dividerBus.start    = issue && owner[3];
    assign dividerBus.op       = opcode;
    assign dividerBus.opA      = rdValue;
    assign dividerBus.opB      = operandB;
    assign dividerBus.carryIn  = carry;

    always_comb begin
        unitResult = aluBus.result;
        unitCarry  = aluBus.carryOut;
        if (owner[1]) begin
            unitResult = shifterBus.result;
            unitCarry  = shifterBus.carryOut;
        end else if (owner[2]) begin
            unitResult = multiplierBus.result;
            unitCarry  = multiplierBus.carryOut;
        end else if (owner[3]) begin
            unitResult = dividerBus.result;
            unitCarry  = dividerBus.carryOut;
        end
    end

    // bus request, held steady by the state while stalled.
    always_comb begin
        read    = 1'b0;
        write   = 1'b0;
        address = pc;
        case (state)
            FETCH0, FETCH1:   read = 1'b1;
            MEMORY0, MEMORY1: begin
                address = memAddress;
                read    = (opcode == LOAD);
                write   = (opcode == STORE);
            end
            default:          address = pc;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            FETCH0:   nextState = FETCH1;
            FETCH1:   nextState = FETCH2;
            FETCH2:   nextState = FETCH3;
            FETCH3:   nextState = DECODE;
            DECODE: begin
                if (opcode == HALT)
                    nextState = HALTED;
                else if (opcode == LOAD || opcode == STORE)
                    nextState = MEMORY0;
                else if (opcode == MOV_I)
                    nextState = EXECUTE1;
                else if (owner != 4'b0000)
                    nextState = EXECUTE0;
                else
                    nextState = FETCH0;   // unknown opcode acts as nop.
            end
            EXECUTE0: nextState = EXECUTE1;
            EXECUTE1: nextState = FETCH0;
            MEMORY0:  nextState = MEMORY1;
            MEMORY1:  nextState = MEMORY2;
            MEMORY2:  nextState = MEMORY3;
            MEMORY3:  nextState = FETCH0;
            default:  nextState = HALTED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= FETCH0;
            pc    <= '0;
            carry <= 1'b0;
        end else if (enable) begin
            state <= nextState;
            if (state == FETCH3)
                pc <= pc + 1'b1;
            if (state == EXECUTE1 && owner != 4'b0000)
                carry <= unitCarry;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            if (state == FETCH3)
                instr <= readData;
            if (state == EXECUTE1 && !compareOnly)
                regs[rd] <= (opcode == MOV_I) ? imm : unitResult;
            if (state == MEMORY3 && opcode == LOAD)
                regs[rd] <= readData[dataWidth-1:0];   // low half of the data path.
        end
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import architecture::*; (
    input logic clk,
    input logic rstN,
    execIf.unit bus
);

    logic [dataWidth:0]   sum;
    logic [dataWidth:0]   diff;
    logic                 withCarry;
    logic                 addOverflow;
    logic                 subOverflow;
    logic [dataWidth-1:0] resultNext;
    logic                 carryNext;
    logic [dataWidth-1:0] result;
    logic                 carryOut;
    logic                 done;

    always_comb begin
        withCarry = bus.carryIn &&
                    (bus.op inside {ADC_I, ADC_R, UADC_I, UADC_R, SBB_I, SBB_R, USBB_I, USBB_R});
        sum  = {1'b0, bus.opA} + {1'b0, bus.opB} + withCarry;
        diff = {1'b0, bus.opA} - {1'b0, bus.opB} - withCarry;   // bit 16 is the borrow.
        addOverflow = (bus.opA[dataWidth-1] == bus.opB[dataWidth-1]) &&
                      (sum[dataWidth-1] != bus.opA[dataWidth-1]);
        subOverflow = (bus.opA[dataWidth-1] != bus.opB[dataWidth-1]) &&
                      (diff[dataWidth-1] != bus.opA[dataWidth-1]);

        resultNext = sum[dataWidth-1:0];
        carryNext  = bus.carryIn;
        case (bus.op)
            ADC_I, ADC_R, ADD_I, ADD_R:     carryNext = addOverflow;
            UADC_I, UADC_R, UADD_I, UADD_R: carryNext = sum[dataWidth];
            SBB_I, SBB_R, SUB_I, SUB_R: begin
                resultNext = diff[dataWidth-1:0];
                carryNext  = subOverflow;
            end
            USBB_I, USBB_R, USUB_I, USUB_R: begin
                resultNext = diff[dataWidth-1:0];
                carryNext  = diff[dataWidth];
            end
            CMP_I, CMP_R: begin
                resultNext = diff[dataWidth-1:0];
                carryNext  = $signed(bus.opA) < $signed(bus.opB);
            end
            UCMP_I, UCMP_R: begin
                resultNext = diff[dataWidth-1:0];
                carryNext  = bus.opA < bus.opB;
            end
            AND_I, AND_R:   resultNext = bus.opA & bus.opB;
            TST_I, TST_R: begin
                resultNext = bus.opA & bus.opB;
                carryNext  = |(bus.opA & bus.opB);   // any common bit set.
            end
            OR_I, OR_R:     resultNext = bus.opA | bus.opB;
            NOT_R:          resultNext = ~bus.opB;
            default:        carryNext = bus.carryIn;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            done <= 1'b0;
        else if (bus.start)
            done <= 1'b1;   // result lands on the same edge.
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            result   <= resultNext;
            carryOut <= carryNext;
        end
    end

    assign bus.result   = result;
    assign bus.carryOut = carryOut;
    assign bus.done     = done;

endmodule

// ==== design/shifter.sv ====
`timescale 1ns/1ps

module shifter import architecture::*; (
    input logic clk,
    input logic rstN,
    execIf.unit bus
);

    opcodes               op;
    logic [dataWidth-1:0] value;
    logic                 carry;
    logic [3:0]           count;
    logic                 busy;
    logic                 done;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (bus.start) begin
            busy <= (bus.opB[3:0] != 4'd0);
            done <= (bus.opB[3:0] == 4'd0);   // zero count is ready at once.
        end else if (busy && count == 4'd1) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            op    <= bus.op;
            value <= bus.opA;
            carry <= bus.carryIn;
            count <= bus.opB[3:0];
        end else if (busy) begin
            count <= count - 1'b1;
            case (op)
                SHL_I, SHL_R: {carry, value} <= {value, 1'b0};
                SHR_I, SHR_R: {value, carry} <= {1'b0, value};
                SAR_I, SAR_R: {value, carry} <= {value[dataWidth-1], value};
                ROL_I, ROL_R: {carry, value} <= {value[dataWidth-1], value[dataWidth-2:0],
                                                 value[dataWidth-1]};
                ROR_I, ROR_R: {value, carry} <= {value[0], value[dataWidth-1:1], value[0]};
                RCL_I, RCL_R: {carry, value} <= {value, carry};
                default:      {value, carry} <= {carry, value};   // rcr.
            endcase
        end
    end

    assign bus.result   = value;
    assign bus.carryOut = carry;
    assign bus.done     = done;

endmodule

// ==== design/multiplier.sv ====
`timescale 1ns/1ps

module multiplier import architecture::*; (
    input logic clk,
    input logic rstN,
    execIf.unit bus
);

    logic [2*dataWidth-1:0] product;
    logic [2*dataWidth-1:0] multiplicand;
    logic [dataWidth-1:0]   multiplierBits;
    logic [dataWidth-1:0]   magA;
    logic [dataWidth-1:0]   magB;
    logic                   signedOp;
    logic                   negative;
    logic [3:0]             steps;
    logic                   busy;
    logic                   done;

    assign signedOp = (bus.op == SMUL_R);
    assign magA     = (signedOp && bus.opA[dataWidth-1]) ? -bus.opA : bus.opA;
    assign magB     = (signedOp && bus.opB[dataWidth-1]) ? -bus.opB : bus.opB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (bus.start) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && steps == 4'd0) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            product        <= '0;
            multiplicand   <= {{dataWidth{1'b0}}, magA};
            multiplierBits <= magB;
            negative       <= signedOp && (bus.opA[dataWidth-1] ^ bus.opB[dataWidth-1]);
            steps          <= 4'(dataWidth - 1);
        end else if (busy) begin
            if (multiplierBits[0])
                product <= product + multiplicand;
            multiplicand   <= multiplicand << 1;
            multiplierBits <= multiplierBits >> 1;
            steps          <= steps - 1'b1;
        end
    end

    // sign applied to the low half only.
    assign bus.result   = negative ? -product[dataWidth-1:0] : product[dataWidth-1:0];
    assign bus.carryOut = |product[2*dataWidth-1:dataWidth];   // magnitude overflow.
    assign bus.done     = done;

endmodule

// ==== design/divider.sv ====
`timescale 1ns/1ps

module divider import architecture::*; (
    input logic clk,
    input logic rstN,
    execIf.unit bus
);

    logic [dataWidth-1:0] remainder;
    logic [dataWidth-1:0] quotient;
    logic [dataWidth-1:0] divisor;
    logic [dataWidth:0]   shifted;
    logic [dataWidth:0]   trial;
    logic [dataWidth-1:0] magA;
    logic [dataWidth-1:0] magB;
    logic                 signedOp;
    logic                 negative;
    logic                 zeroDivisor;
    logic [3:0]           steps;
    logic                 busy;
    logic                 done;

    assign signedOp = (bus.op == SDIV_R);
    assign magA     = (signedOp && bus.opA[dataWidth-1]) ? -bus.opA : bus.opA;
    assign magB     = (signedOp && bus.opB[dataWidth-1]) ? -bus.opB : bus.opB;
    assign shifted  = {remainder, quotient[dataWidth-1]};
    assign trial    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (bus.start) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && steps == 4'd0) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            remainder   <= '0;
            quotient    <= magA;   // dividend shifts out as quotient shifts in.
            divisor     <= magB;
            negative    <= signedOp && (bus.opA[dataWidth-1] ^ bus.opB[dataWidth-1]);
            zeroDivisor <= (bus.opB == '0);
            steps       <= 4'(dataWidth - 1);
        end else if (busy) begin
            steps <= steps - 1'b1;
            if (trial[dataWidth]) begin
                remainder <= shifted[dataWidth-1:0];   // restore.
                quotient  <= {quotient[dataWidth-2:0], 1'b0};
            end else begin
                remainder <= trial[dataWidth-1:0];
                quotient  <= {quotient[dataWidth-2:0], 1'b1};
            end
        end
    end

    assign bus.result   = zeroDivisor ? {dataWidth{1'b1}} : (negative ? -quotient : quotient);
    assign bus.carryOut = zeroDivisor;
    assign bus.done     = done;

endmodule

// ==== design/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore import architecture::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  waitRequest,
    input  logic [instrWidth-1:0] readData,
    input  logic                  readValid,

    output logic [dataWidth-1:0]  address,
    output logic                  read,
    output logic                  write,
    output logic [instrWidth-1:0] writeData,
    output logic                  halted
);

    states  state;
    opcodes opcode;
    logic   enable;

    execIf aluBus ();
    execIf shifterBus ();
    execIf multiplierBus ();
    execIf dividerBus ();

    controller controller0 (
        .clk           (clk),
        .rstN          (rstN),
        .enable        (enable),
        .readData      (readData),
        .state         (state),
        .opcode        (opcode),
        .address       (address),
        .read          (read),
        .write         (write),
        .writeData     (writeData),
        .halted        (halted),
        .aluBus        (aluBus),
        .shifterBus    (shifterBus),
        .multiplierBus (multiplierBus),
        .dividerBus    (dividerBus)
    );

    stallLogic stallLogic0 (
        .state          (state),
        .instruction    (opcode),
        .waitRequest    (waitRequest),
        .readValid      (readValid),
        .aluDone        (aluBus.done),
        .shifterDone    (shifterBus.done),
        .multiplierDone (multiplierBus.done),
        .dividerDone    (dividerBus.done),
        .enable         (enable)
    );

    alu        alu0        (.clk(clk), .rstN(rstN), .bus(aluBus));
    shifter    shifter0    (.clk(clk), .rstN(rstN), .bus(shifterBus));
    multiplier multiplier0 (.clk(clk), .rstN(rstN), .bus(multiplierBus));
    divider    divider0    (.clk(clk), .rstN(rstN), .bus(dividerBus));

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period.
    end

endmodule

// ==== testbench/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb import architecture::*; ();

    localparam int          opCount   = 60;
    localparam logic [15:0] loadBase  = 16'h4000;
    localparam logic [15:0] storeBase = 16'h8000;

    logic                  clk;
    logic                  rstN;
    logic                  waitRequest;
    logic [instrWidth-1:0] readData;
    logic                  readValid;
    logic [dataWidth-1:0]  address;
    logic                  read;
    logic                  write;
    logic [instrWidth-1:0] writeData;
    logic                  halted;

    logic [31:0]           mem [0:65535];
    logic [15:0]           modelRegs [regCount];
    logic                  modelCarry;
    logic [15:0]           expAddr [$];
    logic [15:0]           expData [$];
    int                    instrCount;
    int                    storeIndex;
    int                    cycleCount;
    int                    cycleLimit;

    // memory model state.
    logic                  pending;
    logic [15:0]           reqAddress;
    logic                  reqRead;
    logic                  reqWrite;
    int                    waitLeft;
    int                    validCount;
    logic [31:0]           heldData;

    tbClock clock0 (.clk(clk));

    cpuCore dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .waitRequest (waitRequest),
        .readData    (readData),
        .readValid   (readValid),
        .address     (address),
        .read        (read),
        .write       (write),
        .writeData   (writeData),
        .halted      (halted)
    );

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // reference model of one instruction.
    task automatic referenceStep(input opcodes op, input logic [3:0] rd,
                                 input logic [3:0] rs, input logic [15:0] imm);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] magA;
        logic [15:0] magB;
        logic [15:0] q;
        logic [16:0] wide;
        logic [16:0] ring;
        logic [31:0] prod;
        logic        cin;
        logic        c;
        logic        neg;
        logic        writeRd;
        logic        immForm;
        int          n;
        int          s;

        immForm = (op <= SHR_R) && (int'(op) % 2 == 0);
        a       = modelRegs[rd];
        b       = immForm ? imm : modelRegs[rs];
        cin     = modelCarry && (op inside {ADC_I, ADC_R, UADC_I, UADC_R,
                                            SBB_I, SBB_R, USBB_I, USBB_R});
        res     = a;
        c       = modelCarry;
        writeRd = 1'b1;
        n       = b[3:0];
        neg     = (op inside {SMUL_R, SDIV_R}) && (a[15] ^ b[15]);
        magA    = (op inside {SMUL_R, SDIV_R} && a[15]) ? -a : a;
        magB    = (op inside {SMUL_R, SDIV_R} && b[15]) ? -b : b;
        case (op)
            ADD_I, ADD_R, ADC_I, ADC_R: begin
                res = a + b + cin;
                s   = $signed(a) + $signed(b) + int'(cin);
                c   = (s > 32767) || (s < -32768);   // signed result out of range.
            end
            UADD_I, UADD_R, UADC_I, UADC_R: begin
                wide = a + b + cin;
                res  = wide[15:0];
                c    = wide[16];
            end
            SUB_I, SUB_R, SBB_I, SBB_R: begin
                res = a - b - cin;
                s   = $signed(a) - $signed(b) - int'(cin);
                c   = (s > 32767) || (s < -32768);
            end
            USUB_I, USUB_R, USBB_I, USBB_R: begin
                res = a - b - cin;
                c   = ({1'b0, a} < {1'b0, b} + cin);   // borrow.
            end
            CMP_I, CMP_R: begin
                c       = $signed(a) < $signed(b);
                writeRd = 1'b0;
            end
            UCMP_I, UCMP_R: begin
                c       = a < b;
                writeRd = 1'b0;
            end
            TST_I, TST_R: begin
                c       = |(a & b);
                writeRd = 1'b0;
            end
            AND_I, AND_R: res = a & b;
            OR_I, OR_R:   res = a | b;
            NOT_R:        res = ~b;
            SHL_I, SHL_R: {c, res} = {modelCarry, a} << n;
            SHR_I, SHR_R: {res, c} = {a, modelCarry} >> n;
            SAR_I, SAR_R: {res, c} = $signed({a, modelCarry}) >>> n;
            ROL_I, ROL_R: begin
                res = (a << n) | (a >> (16 - n));
                c   = (n == 0) ? modelCarry : res[0];
            end
            ROR_I, ROR_R: begin
                res = (a >> n) | (a << (16 - n));
                c   = (n == 0) ? modelCarry : res[15];
            end
            RCL_I, RCL_R: begin
                ring     = {modelCarry, a};   // 17-bit ring through carry.
                ring     = (ring << n) | (ring >> (17 - n));
                {c, res} = ring;
            end
            RCR_I, RCR_R: begin
                ring     = {a, modelCarry};
                ring     = (ring >> n) | (ring << (17 - n));
                {res, c} = ring;
            end
            SMUL_R, UMUL_R: begin
                prod = magA * magB;
                res  = a * b;   // low half matches for both signs.
                c    = |prod[31:16];
            end
            SDIV_R, UDIV_R: begin
                if (b == 16'h0000) begin
                    res = 16'hffff;
                    c   = 1'b1;
                end else begin
                    q   = magA / magB;
                    res = neg ? -q : q;
                    c   = 1'b0;
                end
            end
            LOAD:    res = mem[modelRegs[rs] + imm][15:0];
            MOV_I:   res = imm;
            default: writeRd = 1'b0;   // store and halt.
        endcase
        if (writeRd)
            modelRegs[rd] = res;
        modelCarry = c;
    endtask

    task automatic placeInstruction(input opcodes op, input logic [3:0] rd,
                                    input logic [3:0] rs, input logic [15:0] imm);
        mem[instrCount] = {op, rd, rs, 2'b00, imm};
        referenceStep(op, rd, rs, imm);
        instrCount++;
    endtask

    task automatic buildProgram();
        opcodes      op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [15:0] imm;
        int          pick;

        for (int a = 0; a < 65536; a++)
            mem[a] = {~a[15:0], a[15:0]};
        for (int k = 0; k < 64; k++)
            mem[loadBase + k] = $urandom;
        instrCount = 0;
        modelCarry = 1'b0;
        for (int r = 0; r < regCount; r++)
            placeInstruction(MOV_I, 4'(r), 4'd0, 16'($urandom));
        for (int i = 0; i < opCount; i++) begin
            pick = $urandom_range(0, 11);
            if (pick == 0)
                op = opcodes'(int'(SMUL_R) + $urandom_range(0, 3));
            else if (pick == 1)
                op = LOAD;
            else
                op = opcodes'($urandom_range(0, int'(NOT_R)));
            rd  = 4'($urandom);
            rs  = 4'($urandom);
            imm = 16'($urandom);
            if (i == opCount / 2) begin   // forced zero divisor.
                op = ($urandom_range(0, 1) == 1) ? SDIV_R : UDIV_R;
                rs = rd + 1'b1;
                placeInstruction(MOV_I, rs, 4'd0, 16'h0000);
            end
            if (op == LOAD)
                imm = loadBase + 16'($urandom_range(0, 63)) - modelRegs[rs];
            placeInstruction(op, rd, rs, imm);
            rs = 4'($urandom);
            placeInstruction(STORE, rd, rs, storeBase + 16'(i) - modelRegs[rs]);
            expAddr.push_back(storeBase + 16'(i));
            expData.push_back(modelRegs[rd]);
        end
        placeInstruction(HALT, 4'd0, 4'd0, 16'h0000);
    endtask

    // bus memory holds waitRequest high while idle.
    always @(posedge clk) begin
        if (!rstN) begin
            waitRequest <= 1'b1;
            readValid   <= 1'b0;
            pending     = 1'b0;
            validCount  = 0;
        end else begin
            readValid <= 1'b0;
            if (validCount > 0) begin
                validCount--;
                if (validCount == 0) begin
                    readValid <= 1'b1;
                    readData  <= heldData;
                end
            end
            if (pending) begin
                checkValue("address (held)", address, reqAddress);
                checkValue("read (held)", read, reqRead);
                checkValue("write (held)", write, reqWrite);
                if (!waitRequest) begin
                    pending = 1'b0;
                    waitRequest <= 1'b1;
                    if (reqRead) begin
                        heldData   = mem[reqAddress];
                        validCount = $urandom_range(1, 3);
                    end else begin
                        if (storeIndex >= expAddr.size())
                            stopWithFailure("The core wrote more data than the program stores.");
                        checkValue("store address", reqAddress, expAddr[storeIndex]);
                        checkValue("writeData", writeData, {16'h0000, expData[storeIndex]});
                        storeIndex++;
                    end
                end else if (waitLeft > 0) begin
                    waitLeft--;
                    if (waitLeft == 0)
                        waitRequest <= 1'b0;
                end
            end else if (read || write) begin
                if (halted === 1'b1)
                    stopWithFailure("The core made a bus request after it halted.");
                pending    = 1'b1;
                reqAddress = address;
                reqRead    = read;
                reqWrite   = write;
                waitLeft   = $urandom_range(0, 3);
                if (waitLeft == 0)
                    waitRequest <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
            stopWithFailure("Timeout: the core did not halt in time.");
    end

    initial begin
        rstN        = 1'b0;
        waitRequest = 1'b1;
        readData    = '0;
        readValid   = 1'b0;
        storeIndex  = 0;
        cycleCount  = 0;
        void'($urandom(32'hd04e));
        buildProgram();
        cycleLimit = 80 * instrCount + 200;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        do
            @(posedge clk);
        while (halted !== 1'b1);
        checkValue("store count", storeIndex, expAddr.size());
        repeat (10) @(posedge clk);   // bus stays idle.
        if (halted === 1'b1) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stopWithFailure("halted dropped after the core stopped.");
        end
    end

endmodule

// ==== sources.f ====
design/architecture.sv
design/execIf.sv
design/stallLogic.sv
design/controller.sv
design/alu.sv
design/shifter.sv
design/multiplier.sv
design/divider.sv
design/cpuCore.sv
testbench/tbClock.sv
testbench/cpuCoreTb.sv
